//--- Makefile
# Verilator build and run of the instruction front end testbench

OBJ = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -sv -f sources.f \
		--top-module tb_frontend -Mdir $(OBJ)

run: build
	./$(OBJ)/Vtb_frontend | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	verilator --lint-only --timescale 1ns/1ps -sv common/fetch_pkg.sv \
		fetch/inst_mem.sv fetch/inst_fetch.sv verilog/static_predictor.sv \
		verilog/frontend_top.sv --top-module frontend_top

clean:
	rm -rf $(OBJ) $(LOG)

//--- common/fetch_pkg.sv
package fetch_pkg;

    // ======================================================================
    // widths
    // ======================================================================
    localparam int XLEN = 32;               // data and address width

    // instruction memory depth as a word address width, 1024 words
    localparam int IMEM_AW_DEF = 10;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC_DEF = 32'h0000_0000;

    // ======================================================================
    // opcodes seen by the static predictor
    // ======================================================================
    localparam logic [6:0] OPC_JAL    = 7'b1101111;    // jal rd, imm
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;    // beq/bne/blt/bge/bltu/bgeu

    // addi x0, x0, 0
    // shown in ID while no valid instruction sits there
    localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

endpackage

//--- fetch/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch #(
    parameter int                           IMEM_AW  = 10,
    parameter logic [fetch_pkg::XLEN-1:0]   RESET_PC = 32'h0
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        enable_i,       // stage enable, low holds IF

    // redirect from the static predictor in ID
    input  logic                        taken_d_i,
    input  logic [fetch_pkg::XLEN-1:0]  redirection_d_i,

    // instruction memory side
    input  logic [fetch_pkg::XLEN-1:0]  instr_mem_i,    // registered memory output
    output logic [IMEM_AW-1:0]          imem_addr_o,    // word address
    output logic                        imem_rd_en_o,

    // IF outputs towards ID
    output logic [fetch_pkg::XLEN-1:0]  instr_f_o,
    output logic [fetch_pkg::XLEN-1:0]  pc_f_o,
    output logic [fetch_pkg::XLEN-1:0]  pc_plus4_f_o,
    output logic                        valid_f_o
);

    // ======================================================================
    // pc state
    // ======================================================================
    logic [fetch_pkg::XLEN-1:0] next_pc;    // sequential successor of pc_f
    logic [fetch_pkg::XLEN-1:0] fetch_pc;   // address handed to memory this cycle

    // predicted-taken branch in IF wins over the sequential path
    assign fetch_pc = taken_d_i ? redirection_d_i : next_pc;

    // byte pc to word address, upper bits beyond the memory are dropped
    assign imem_addr_o  = fetch_pc[IMEM_AW+1:2];
    assign imem_rd_en_o = enable_i;            // memory output moves with the stage

    // control part of the IF register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            next_pc   <= RESET_PC;
            valid_f_o <= 1'b0;
        end else if (enable_i) begin
            next_pc   <= fetch_pc + 32'd4;
            valid_f_o <= 1'b1;                 // first enabled edge fills IF
        end
    end

    // pc of the word now arriving from memory
    always_ff @(posedge clk) begin
        if (enable_i) begin
            pc_f_o <= fetch_pc;
        end
    end

    // ======================================================================
    // IF outputs
    // ======================================================================
    // memory already delays by one edge, so the word lines up with pc_f
    assign instr_f_o    = instr_mem_i;
    assign pc_plus4_f_o = next_pc;             // same value as pc_f + 4 once valid

endmodule

//--- fetch/inst_mem.sv
`timescale 1ns/1ps

module inst_mem #(
    parameter int IMEM_AW = 10
) (
    input  logic                        clk,
    input  logic                        resetn,

    // fetch read port
    input  logic                        rd_en_i,
    input  logic [IMEM_AW-1:0]          rd_addr_i,      // word address
    output logic [fetch_pkg::XLEN-1:0]  instr_o,

    // wishbone classic slave, program load
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [fetch_pkg::XLEN-1:0]  wb_adr_i,       // byte address
    input  logic [fetch_pkg::XLEN-1:0]  wb_dat_i,
    output logic                        wb_ack_o
);

    localparam int DEPTH = 1 << IMEM_AW;

    // ======================================================================
    // storage
    // ======================================================================
    logic [fetch_pkg::XLEN-1:0] mem [0:DEPTH-1];

    logic                       wb_req;         // new access, ack not yet given
    logic                       wb_wr;          // new write access
    logic [IMEM_AW-1:0]         wb_word;        // word index of the access

    assign wb_req  = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wb_wr   = wb_req && wb_we_i;
    assign wb_word = wb_adr_i[IMEM_AW+1:2];    // byte lanes are ignored

    // registered read, output holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            instr_o <= mem[rd_addr_i];
        end
    end

    // write side, only full words
    always_ff @(posedge clk) begin
        if (wb_wr) begin
            mem[wb_word] <= wb_dat_i;
        end
    end

    // ======================================================================
    // wishbone handshake
    // ======================================================================
    // one ack per access, then a low cycle before the next one
    // reads get acked too, there is no read data path
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_req;
        end
    end

endmodule

//--- sources.f
common/fetch_pkg.sv
fetch/inst_mem.sv
fetch/inst_fetch.sv
verilog/static_predictor.sv
verilog/frontend_top.sv
test/tb_frontend.sv

//--- test/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

    localparam int          IMEM_AW     = 10;
    localparam logic [31:0] RESET_PC    = 32'h0;
    localparam int          TBL_LEN     = 24;      // program rows
    localparam int          N_ENTRIES   = 40;      // model length, bounds the backward loop
    localparam int          WATCHDOG_NS = (TBL_LEN + N_ENTRIES) * 8 * 4;

    // row kinds of the program table
    localparam int K_PLAIN  = 0;
    localparam int K_BRANCH = 1;
    localparam int K_JAL    = 2;

    logic        clk;
    logic        resetn;
    logic        fetch_en_i;
    logic        stall_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic        wb_ack_o;
    logic [31:0] instr_d_o;
    logic [31:0] pc_d_o;
    logic        pred_taken_d_o;
    logic        valid_d_o;

    // program table: word, kind and offset per row
    logic [31:0] tbl_word [TBL_LEN];
    int          tbl_kind [TBL_LEN];
    int          tbl_imm  [TBL_LEN];

    // expected decode sequence
    logic [31:0] exp_pc    [N_ENTRIES];
    logic [31:0] exp_instr [N_ENTRIES];
    bit          exp_taken [N_ENTRIES];

    int          errors     = 0;
    int          checks     = 0;
    int          tests_run  = 0;
    int          tests_bad  = 0;
    int          ack_count  = 0;
    int          err_start;
    logic [31:0] lcg_state  = 32'd79;

    frontend_top #(
        .IMEM_AW        (IMEM_AW),
        .RESET_PC       (RESET_PC)
    ) frontend_top_inst (
        .clk            (clk),
        .resetn         (resetn),
        .fetch_en_i     (fetch_en_i),
        .stall_i        (stall_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_o       (wb_ack_o),
        .instr_d_o      (instr_d_o),
        .pc_d_o         (pc_d_o),
        .pred_taken_d_o (pred_taken_d_o),
        .valid_d_o      (valid_d_o)
    );

    always #2 clk = ~clk;                       // 4 ns period

    // one count per ack cycle, sampled away from the rising edge
    always @(negedge clk) begin
        if (wb_ack_o === 1'b1) begin
            ack_count++;
        end
    end

    // ======================================================================
    // instruction encoding
    // ======================================================================
    function automatic logic [31:0] enc_addi(input int rd, input int imm);
        logic [31:0] i;
        logic [31:0] r;
        i = imm;
        r = rd;
        return {i[11:0], 5'd0, 3'b000, r[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_branch(input int rs1, input int rs2, input int off);
        logic [31:0] o;
        logic [31:0] a;
        logic [31:0] b;
        o = off;
        a = rs1;
        b = rs2;
        return {o[12], o[10:5], b[4:0], a[4:0], 3'b001, o[4:1], o[11], fetch_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input int rd, input int off);
        logic [31:0] o;
        logic [31:0] r;
        o = off;
        r = rd;
        return {o[20], o[10:1], o[11], o[19:12], r[4:0], fetch_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic put_row(input int idx, input int kind, input int off, input logic [31:0] w);
        tbl_kind[idx] = kind;
        tbl_imm[idx]  = off;
        tbl_word[idx] = w;
    endtask

    // straight code, forward bne at 24, jal at 32, loop 56..68 closed by bne
    task automatic fill_table();
        for (int i = 0; i < TBL_LEN; i++) begin
            put_row(i, K_PLAIN, 0, fetch_pkg::INSTR_NOP);   // filler, skipped rows
        end
        for (int i = 0; i < 6; i++) begin
            put_row(i, K_PLAIN, 0, enc_addi(i + 1, i + 1));
        end
        put_row(6,  K_BRANCH, 12,  enc_branch(1, 2, 12));
        put_row(7,  K_PLAIN,  0,   enc_addi(7, 7));
        put_row(8,  K_JAL,    24,  enc_jal(1, 24));
        put_row(14, K_PLAIN,  0,   enc_addi(8, 8));
        put_row(15, K_PLAIN,  0,   enc_addi(9, 9));
        put_row(16, K_PLAIN,  0,   enc_addi(10, 10));
        put_row(17, K_BRANCH, -12, enc_branch(8, 9, -12));
    endtask

    // walk the table by the static rule
    task automatic build_model();
        logic [31:0] pc;
        int          i;
        bit          taken;
        pc = RESET_PC;
        for (int n = 0; n < N_ENTRIES; n++) begin
            i = int'(pc >> 2);
            exp_pc[n]    = pc;
            exp_instr[n] = (i < TBL_LEN) ? tbl_word[i] : fetch_pkg::INSTR_NOP;
            taken = (i < TBL_LEN) && (tbl_kind[i] == K_JAL ||
                    (tbl_kind[i] == K_BRANCH && tbl_imm[i] < 0));
            exp_taken[n] = taken;
            pc = taken ? pc + 32'(tbl_imm[i]) : pc + 32'd4;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_bad++;
        end
        $display("[%s] done, %0d mismatches", name, errors - err_before);
    endtask

    // ======================================================================
    // stimulus tasks, all return 1 ns after a rising edge
    // ======================================================================
    task automatic apply_reset();
        resetn     = 1'b0;
        fetch_en_i = 1'b0;
        stall_i    = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        resetn = 1'b1;
    endtask

    task automatic load_word(input int idx);
        int waited;
        bit got;
        waited   = 0;
        got      = 1'b0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = 32'(idx) << 2;               // byte address
        wb_dat_i = tbl_word[idx];
        while (!got && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
            got = wb_ack_o;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!got) begin
            errors++;
            $display("load: no acknowledge for the write to address %h", wb_adr_i);
        end
        @(posedge clk);                         // ack drops here
        #1;
        check_value("valid_d during load", 32'(valid_d_o), 32'd0);
    endtask

    task automatic drive_stall(input bit stalls);
        if (stalls) begin
            lcg_state = lcg_next(lcg_state);
            stall_i   = lcg_state[20];
        end else begin
            stall_i = 1'b0;
        end
    endtask

    // compare each new ID entry against the model from its first row
    task automatic run_capture(input int n, input bit stalls, input string name);
        int idx;
        int cycles;
        bit en_prev;
        idx        = 0;
        cycles     = 0;
        fetch_en_i = 1'b1;
        drive_stall(stalls);
        en_prev = !stall_i;                     // enable seen by the coming edge
        while (idx < n && cycles < n * 8) begin
            @(posedge clk);
            #1;
            cycles++;
            if (en_prev && valid_d_o) begin
                check_value({name, " pc_d"}, pc_d_o, exp_pc[idx]);
                check_value({name, " instr_d"}, instr_d_o, exp_instr[idx]);
                check_value({name, " pred_taken_d"}, 32'(pred_taken_d_o),
                            32'(exp_taken[idx]));
                idx++;
            end
            drive_stall(stalls);
            en_prev = !stall_i;
        end
        if (idx < n) begin
            errors++;
            $display("%s: only %0d of %0d instructions reached decode in %0d cycles",
                     name, idx, n, cycles);
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        fetch_en_i = 1'b0;
        stall_i    = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = 32'd0;
        wb_dat_i   = 32'd0;
        fill_table();
        build_model();
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;

        err_start = errors;
        for (int i = 0; i < TBL_LEN; i++) begin
            load_word(i);
        end
        check_value("ack count after load", 32'(ack_count), 32'(TBL_LEN));
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        check_value("ack count while idle", 32'(ack_count), 32'(TBL_LEN));
        check_value("valid_d while idle", 32'(valid_d_o), 32'd0);
        finish_test("load", err_start);

        err_start = errors;
        run_capture(N_ENTRIES, 1'b0, "fetch");  // sequential, jal and both branches
        finish_test("fetch without stalls", err_start);

        err_start = errors;
        apply_reset();
        run_capture(N_ENTRIES, 1'b1, "stall");
        finish_test("random stalls", err_start);

        err_start = errors;
        apply_reset();
        run_capture(6, 1'b0, "before reset");
        resetn = 1'b0;                          // pipeline keeps running until here
        @(posedge clk);
        #1;
        check_value("valid_d in reset", 32'(valid_d_o), 32'd0);
        @(posedge clk);
        #1;
        resetn = 1'b1;
        run_capture(13, 1'b0, "after reset");
        finish_test("reset mid-run", err_start);

        $display("summary: %0d tests, %0d with mismatches, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog, 8 cycles per table row and model entry
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

//--- verilog/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter int                           IMEM_AW  = fetch_pkg::IMEM_AW_DEF,
    parameter logic [fetch_pkg::XLEN-1:0]   RESET_PC = fetch_pkg::RESET_PC_DEF
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        fetch_en_i,     // low while the host loads code
    input  logic                        stall_i,        // back-pressure from later stages

    // program load port
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [fetch_pkg::XLEN-1:0]  wb_adr_i,
    input  logic [fetch_pkg::XLEN-1:0]  wb_dat_i,
    output logic                        wb_ack_o,

    // ID stage outputs
    output logic [fetch_pkg::XLEN-1:0]  instr_d_o,
    output logic [fetch_pkg::XLEN-1:0]  pc_d_o,
    output logic                        pred_taken_d_o,
    output logic                        valid_d_o
);

    // ======================================================================
    // internal nets
    // ======================================================================
    logic                       stage_en;       // common enable of IF, ID and memory

    logic [IMEM_AW-1:0]         imem_addr;
    logic                       imem_rd_en;
    logic [fetch_pkg::XLEN-1:0] imem_instr;

    logic [fetch_pkg::XLEN-1:0] instr_f;
    logic [fetch_pkg::XLEN-1:0] pc_f;
    logic                       valid_f;

    logic                       taken_d;
    logic [fetch_pkg::XLEN-1:0] redirection_d;

    assign stage_en = fetch_en_i && !stall_i;

    // instruction memory with load port
    inst_mem #(
        .IMEM_AW    (IMEM_AW)
    ) inst_mem_inst (
        .clk        (clk),
        .resetn     (resetn),
        .rd_en_i    (imem_rd_en),
        .rd_addr_i  (imem_addr),
        .instr_o    (imem_instr),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_o   (wb_ack_o)
    );

    // IF stage
    inst_fetch #(
        .IMEM_AW            (IMEM_AW),
        .RESET_PC           (RESET_PC)
    ) inst_fetch_inst (
        .clk                (clk),
        .resetn             (resetn),
        .enable_i           (stage_en),
        .taken_d_i          (taken_d),
        .redirection_d_i    (redirection_d),
        .instr_mem_i        (imem_instr),
        .imem_addr_o        (imem_addr),
        .imem_rd_en_o       (imem_rd_en),
        .instr_f_o          (instr_f),
        .pc_f_o             (pc_f),
        .pc_plus4_f_o       (),                 // link address, no consumer in this front end
        .valid_f_o          (valid_f)
    );

    // ID stage with static prediction
    static_predictor static_predictor_inst (
        .clk                (clk),
        .resetn             (resetn),
        .enable_i           (stage_en),
        .instr_f_i          (instr_f),
        .pc_f_i             (pc_f),
        .valid_f_i          (valid_f),
        .taken_d_o          (taken_d),
        .redirection_d_o    (redirection_d),
        .instr_d_o          (instr_d_o),
        .pc_d_o             (pc_d_o),
        .pred_taken_d_o     (pred_taken_d_o),
        .valid_d_o          (valid_d_o)
    );

endmodule

//--- verilog/static_predictor.sv
`timescale 1ns/1ps

module static_predictor (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        enable_i,       // stage enable, low holds ID

    // IF contents
    input  logic [fetch_pkg::XLEN-1:0]  instr_f_i,
    input  logic [fetch_pkg::XLEN-1:0]  pc_f_i,
    input  logic                        valid_f_i,

    // redirect back to fetch, same cycle
    output logic                        taken_d_o,
    output logic [fetch_pkg::XLEN-1:0]  redirection_d_o,

    // ID stage register
    output logic [fetch_pkg::XLEN-1:0]  instr_d_o,
    output logic [fetch_pkg::XLEN-1:0]  pc_d_o,
    output logic                        pred_taken_d_o,
    output logic                        valid_d_o
);

    // ======================================================================
    // decode
    // ======================================================================
    logic [6:0]                 opcode;
    logic                       is_jal;
    logic                       is_branch;
    logic [fetch_pkg::XLEN-1:0] imm_j;      // jal offset, sign extended
    logic [fetch_pkg::XLEN-1:0] imm_b;      // branch offset, sign extended
    logic [fetch_pkg::XLEN-1:0] imm_sel;

    assign opcode    = instr_f_i[6:0];
    assign is_jal    = (opcode == fetch_pkg::OPC_JAL);
    assign is_branch = (opcode == fetch_pkg::OPC_BRANCH);

    // J-type: imm[20|10:1|11|19:12]
    assign imm_j = {{11{instr_f_i[31]}}, instr_f_i[31], instr_f_i[19:12],
                    instr_f_i[20], instr_f_i[30:21], 1'b0};

    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign imm_b = {{19{instr_f_i[31]}}, instr_f_i[31], instr_f_i[7],
                    instr_f_i[30:25], instr_f_i[11:8], 1'b0};

    assign imm_sel = is_jal ? imm_j : imm_b;

    // ======================================================================
    // prediction
    // ======================================================================
    // jal always taken
    // backward branch (loop) taken, forward branch falls through
    assign taken_d_o = valid_f_i && (is_jal || (is_branch && imm_b[31]));

    // only meaningful while taken_d_o is high
    assign redirection_d_o = pc_f_i + imm_sel;

    // ID register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            instr_d_o      <= fetch_pkg::INSTR_NOP;
            pc_d_o         <= 32'h0;
            pred_taken_d_o <= 1'b0;
            valid_d_o      <= 1'b0;
        end else if (enable_i) begin
            // empty IF slot turns into a bubble
            instr_d_o      <= valid_f_i ? instr_f_i : fetch_pkg::INSTR_NOP;
            pc_d_o         <= pc_f_i;
            pred_taken_d_o <= taken_d_o;        // already masked by valid_f
            valid_d_o      <= valid_f_i;
        end
    end

endmodule
